// File: tb.f
logic/cu_ctrl_pkg.sv
logic/cu_mem_pkg.sv
logic/cu_config_regs.sv
logic/cu_control.sv
logic/cu_setup_engine.sv
logic/cu_fifo.sv
logic/cu_wb_master.sv
logic/cu_top.sv
tests/wb_mem_model.sv
tests/tb_cu_top.sv

// File: Bender.yml
package:
  name: cu_setup

sources:
  - files:
      - logic/cu_ctrl_pkg.sv
      - logic/cu_mem_pkg.sv
      - logic/cu_config_regs.sv
      - logic/cu_control.sv
      - logic/cu_setup_engine.sv
      - logic/cu_fifo.sv
      - logic/cu_wb_master.sv
      - logic/cu_top.sv
  - target: test
    files:
      - tests/wb_mem_model.sv
      - tests/tb_cu_top.sv

// File: tests/tb_cu_top.sv
// Testbench for the compute unit setup path
//   Clock, reset, Wishbone memory model
//   Directed test tasks with immediate checks and a closing report
module tb_cu_top;
  timeunit 1ns;
  timeprecision 1ps;

  import cu_mem_pkg::*;
  import cu_ctrl_pkg::*;

  localparam int    SETTLE     = 16;
  localparam int    DEPTH      = 8;
  localparam int    WAIT_LIMIT = 4000;
  localparam data_t PATTERN    = 32'h5a5a0000;

  logic   ap_clk;
  logic   control_areset;
  logic   ap_start;
  logic   ap_continue;
  logic   ap_ready;
  logic   ap_idle;
  logic   ap_done;
  logic   desc_valid;
  addr_t  desc_base;
  count_t desc_count;
  logic   wb_cyc;
  logic   wb_stb;
  addr_t  wb_adr;
  data_t  wb_dat;
  logic   wb_ack;
  logic   cfg_valid;
  data_t  cfg_data;
  logic   cfg_ready;

  integer seed = 32'hc24d;
  int     error_count = 0;
  int     check_count = 0;

  cu_top #(.SETTLE_CYCLES(SETTLE), .FIFO_DEPTH(DEPTH)) dut0 (
    .ap_clk     (ap_clk),     .control_areset(control_areset),
    .ap_start   (ap_start),   .ap_continue   (ap_continue),
    .ap_ready   (ap_ready),   .ap_idle       (ap_idle),
    .ap_done    (ap_done),    .desc_valid    (desc_valid),
    .desc_base  (desc_base),  .desc_count    (desc_count),
    .wb_cyc     (wb_cyc),     .wb_stb        (wb_stb),
    .wb_adr     (wb_adr),     .wb_dat        (wb_dat),
    .wb_ack     (wb_ack),     .cfg_valid     (cfg_valid),
    .cfg_data   (cfg_data),   .cfg_ready     (cfg_ready)
  );

  wb_mem_model u_mem (
    .ap_clk(ap_clk), .control_areset(control_areset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
    .wb_dat(wb_dat), .wb_ack(wb_ack)
  );

  // 4 ns clock
  initial begin
    ap_clk = 1'b0;
    forever #2 ap_clk = ~ap_clk;
  end

  // --------------------------------------------------
  // Check helpers
  // --------------------------------------------------
  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    check_count++;
    assert (expected == actual) else begin
      error_count++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic confirm(input logic cond, input string what);
    check_count++;
    assert (cond) else begin
      error_count++;
      $display("error: %s", what);
    end
  endtask

  task automatic report_timeout(input string name, input string what);
    error_count++;
    $display("error: %s timed out waiting for %s", name, what);
  endtask

  // One-cycle descriptor strobe
  task automatic load_descriptor(input addr_t base, input count_t count);
    @(posedge ap_clk);
    desc_valid <= 1'b1;
    desc_base  <= base;
    desc_count <= count;
    @(posedge ap_clk);
    desc_valid <= 1'b0;
  endtask

  // --------------------------------------------------
  // Full run: descriptor, start, collect, done, continue
  // --------------------------------------------------
  task automatic run_descriptor(input string name, input addr_t base, input count_t count,
                                input bit random_ready);
    int    got;
    int    bus_words;
    int    cycle;
    int    last_cycle;
    bit    bus_seen;
    data_t expected;
    got        = 0;
    bus_words  = 0;
    last_cycle = 0;
    bus_seen   = 1'b0;
    load_descriptor(base, count);
    ap_start <= 1'b1;
    // Start handshake
    cycle = 0;
    @(posedge ap_clk);
    while (!ap_ready && cycle < WAIT_LIMIT) begin
      @(posedge ap_clk);
      cycle++;
    end
    ap_start <= 1'b0;
    if (!ap_ready) begin
      report_timeout(name, "ap_ready");
      return;
    end
    // Collect words until ap_done
    cycle = 0;
    while (!ap_done && cycle < WAIT_LIMIT) begin
      @(posedge ap_clk);
      cycle++;
      if (wb_cyc) bus_seen = 1'b1;
      // Each acked bus read walks one word further from base
      if (wb_cyc && wb_stb && wb_ack) begin
        compare_value(name, base + addr_t'(bus_words), wb_adr);
        bus_words++;
      end
      if (cfg_valid && cfg_ready) begin
        expected = (base + addr_t'(got)) ^ PATTERN;
        compare_value(name, expected, cfg_data);
        got++;
        last_cycle = cycle;
      end
      // Mostly low ready lets the response FIFO fill up
      cfg_ready <= random_ready ? ($random(seed) % 8 == 0) : 1'b1;
    end
    cfg_ready <= 1'b1;
    if (!ap_done) begin
      report_timeout(name, "ap_done");
      return;
    end
    compare_value(name, 32'(count), got);
    compare_value(name, 32'(count), bus_words);
    if (count == '0) begin
      confirm(!bus_seen, $sformatf("%s: bus cycle on a zero-count run", name));
    end else begin
      // Drain seen at the earliest one cycle after the last word
      confirm(cycle - last_cycle > SETTLE,
              $sformatf("%s: ap_done rose before the settle delay", name));
    end
    // ap_done holds until ap_continue
    repeat (4) begin
      @(posedge ap_clk);
      confirm(ap_done, $sformatf("%s: ap_done dropped before ap_continue", name));
    end
    ap_continue <= 1'b1;
    @(posedge ap_clk);
    ap_continue <= 1'b0;
    cycle = 0;
    while (!ap_idle && cycle < WAIT_LIMIT) begin
      @(posedge ap_clk);
      cycle++;
    end
    confirm(ap_idle, $sformatf("%s: ap_idle did not return after ap_continue", name));
    confirm(!cfg_valid, $sformatf("%s: extra word after ap_done", name));
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic reset_values();
    @(posedge ap_clk);
    compare_value("reset_values ap_idle", 1, ap_idle);
    compare_value("reset_values ap_ready", 0, ap_ready);
    compare_value("reset_values ap_done", 0, ap_done);
    compare_value("reset_values wb_cyc", 0, wb_cyc);
    compare_value("reset_values wb_stb", 0, wb_stb);
    compare_value("reset_values cfg_valid", 0, cfg_valid);
  endtask

  task automatic start_without_descriptor();
    ap_start <= 1'b1;
    repeat (20) begin
      @(posedge ap_clk);
      confirm(ap_idle, "start_without_descriptor: ap_idle fell");
      confirm(!ap_ready, "start_without_descriptor: ap_ready pulsed");
      confirm(!wb_cyc, "start_without_descriptor: bus cycle started");
    end
    ap_start <= 1'b0;
  endtask

  initial begin
    control_areset = 1'b1;
    ap_start       = 1'b0;
    ap_continue    = 1'b0;
    desc_valid     = 1'b0;
    desc_base      = '0;
    desc_count     = '0;
    cfg_ready      = 1'b1;
    repeat (8) @(posedge ap_clk);
    control_areset <= 1'b0;

    reset_values();
    run_descriptor("basic_run", 32'h0000_0100, 16'd12, 1'b0);
    run_descriptor("backpressure_run", 32'h0000_0400, 16'd40, 1'b1);
    start_without_descriptor();
    run_descriptor("zero_count_run", 32'h0000_0800, 16'd0, 1'b0);
    run_descriptor("settle_delay_run", 32'h0000_0c00, 16'd3, 1'b0);

    repeat (4) @(posedge ap_clk);
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule : tb_cu_top

// File: tests/wb_mem_model.sv
// Wishbone classic slave memory model
//   Word at address a reads as a XOR 32'h5a5a0000
//   Ack after 0 to 3 extra wait cycles, seeded random
module wb_mem_model (
  input  logic              ap_clk,
  input  logic              control_areset,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  cu_mem_pkg::addr_t wb_adr,
  output cu_mem_pkg::data_t wb_dat,
  output logic              wb_ack
);
  timeunit 1ns;
  timeprecision 1ps;

  import cu_mem_pkg::*;

  localparam data_t PATTERN = 32'h5a5a0000;

  integer     seed = 32'hc24d;
  int         delay;
  logic [1:0] wait_left;
  logic       busy;

  // Read data follows the address, only sampled with ack
  assign wb_dat = wb_adr ^ PATTERN;

  // --------------------------------------------------
  // Ack generation
  // --------------------------------------------------
  always @(posedge ap_clk) begin
    if (control_areset) begin
      wb_ack    <= 1'b0;
      busy      <= 1'b0;
      wait_left <= '0;
    end else if (wb_ack) begin
      // Single-cycle ack, master drops stb here
      wb_ack <= 1'b0;
      busy   <= 1'b0;
    end else if (wb_cyc && wb_stb && !busy) begin
      // New request, draw its wait states
      delay = $unsigned($random(seed)) % 4;
      busy  <= 1'b1;
      if (delay == 0) begin
        wb_ack <= 1'b1;
      end else begin
        wait_left <= 2'(delay);
      end
    end else if (busy) begin
      if (wait_left == 2'd1) wb_ack <= 1'b1;
      wait_left <= wait_left - 2'd1;
    end
  end

endmodule : wb_mem_model

// File: logic/cu_top.sv
// Compute unit setup path, top level
//   Descriptor regs, control FSM, setup engine
//   Request FIFO, Wishbone read master, response FIFO
module cu_top #(
  parameter int SETTLE_CYCLES = cu_ctrl_pkg::SETTLE_CYCLES_DEFAULT,
  parameter int FIFO_DEPTH    = cu_mem_pkg::FIFO_DEPTH_DEFAULT
) (
  input  logic                ap_clk,
  input  logic                control_areset,
  input  logic                ap_start,
  input  logic                ap_continue,
  output logic                ap_ready,
  output logic                ap_idle,
  output logic                ap_done,
  input  logic                desc_valid,
  input  cu_mem_pkg::addr_t   desc_base,
  input  cu_ctrl_pkg::count_t desc_count,
  output logic                wb_cyc,
  output logic                wb_stb,
  output cu_mem_pkg::addr_t   wb_adr,
  input  cu_mem_pkg::data_t   wb_dat,
  input  logic                wb_ack,
  output logic                cfg_valid,
  output cu_mem_pkg::data_t   cfg_data,
  input  logic                cfg_ready
);

  import cu_mem_pkg::*;
  import cu_ctrl_pkg::*;

  // --------------------------------------------------
  // Internal wires
  // --------------------------------------------------
  addr_t  cfg_base;
  count_t cfg_count;
  logic   desc_loaded, desc_consume, run_start, issue_done, mem_idle;
  logic   req_push, req_pop, req_full, req_empty;
  addr_t  req_addr, req_head;
  logic   rsp_push, rsp_pop, rsp_full, rsp_empty;
  data_t  rsp_data;

  // Output stream is the response FIFO head
  assign cfg_valid = ~rsp_empty;
  assign rsp_pop   = cfg_valid & cfg_ready;

  cu_config_regs u_config_regs (
    .ap_clk        (ap_clk),         .control_areset(control_areset),
    .desc_valid    (desc_valid),     .desc_base     (desc_base),
    .desc_count    (desc_count),     .desc_consume  (desc_consume),
    .desc_loaded   (desc_loaded),    .cfg_base      (cfg_base),
    .cfg_count     (cfg_count)
  );

  cu_control #(.SETTLE_CYCLES(SETTLE_CYCLES)) u_control (
    .ap_clk     (ap_clk),      .control_areset(control_areset),
    .ap_start   (ap_start),    .ap_continue   (ap_continue),
    .desc_loaded(desc_loaded), .issue_done    (issue_done),
    .mem_idle   (mem_idle),    .req_empty     (req_empty),
    .rsp_empty  (rsp_empty),   .ap_ready      (ap_ready),
    .ap_idle    (ap_idle),     .ap_done       (ap_done),
    .run_start  (run_start),   .desc_consume  (desc_consume)
  );

  cu_setup_engine u_setup_engine (
    .ap_clk   (ap_clk),    .control_areset(control_areset),
    .run_start(run_start), .cfg_base      (cfg_base),
    .cfg_count(cfg_count), .req_full      (req_full),
    .req_push (req_push),  .req_addr      (req_addr),
    .issue_done(issue_done)
  );

  // Address requests toward the bus
  cu_fifo #(.payload_t(addr_t), .DEPTH(FIFO_DEPTH)) u_req_fifo (
    .ap_clk(ap_clk),     .control_areset(control_areset),
    .push  (req_push),   .push_data     (req_addr),
    .pop   (req_pop),    .pop_data      (req_head),
    .full  (req_full),   .empty         (req_empty)
  );

  cu_wb_master u_wb_master (
    .ap_clk   (ap_clk),    .control_areset(control_areset),
    .req_empty(req_empty), .req_addr      (req_head),
    .rsp_full (rsp_full),  .wb_dat        (wb_dat),
    .wb_ack   (wb_ack),    .req_pop       (req_pop),
    .rsp_push (rsp_push),  .rsp_data      (rsp_data),
    .wb_cyc   (wb_cyc),    .wb_stb        (wb_stb),
    .wb_adr   (wb_adr),    .mem_idle      (mem_idle)
  );

  // Configuration words toward the output stream
  cu_fifo #(.payload_t(data_t), .DEPTH(FIFO_DEPTH)) u_rsp_fifo (
    .ap_clk(ap_clk),     .control_areset(control_areset),
    .push  (rsp_push),   .push_data     (rsp_data),
    .pop   (rsp_pop),    .pop_data      (cfg_data),
    .full  (rsp_full),   .empty         (rsp_empty)
  );

endmodule : cu_top

// File: logic/cu_wb_master.sv
// Wishbone classic read master
//   Single outstanding read, request FIFO in, response FIFO out
//   No write path, so no wb_we
module cu_wb_master (
  input  logic              ap_clk,
  input  logic              control_areset,
  input  logic              req_empty,
  input  cu_mem_pkg::addr_t req_addr,
  input  logic              rsp_full,
  input  cu_mem_pkg::data_t wb_dat,
  input  logic              wb_ack,
  output logic              req_pop,
  output logic              rsp_push,
  output cu_mem_pkg::data_t rsp_data,
  output logic              wb_cyc,
  output logic              wb_stb,
  output cu_mem_pkg::addr_t wb_adr,
  output logic              mem_idle
);

  // Open a cycle only with an address and room for the reply
  assign req_pop  = ~wb_cyc & ~req_empty & ~rsp_full;
  // Reply goes straight into the response FIFO
  assign rsp_push = wb_stb & wb_ack;
  assign rsp_data = wb_dat;
  assign mem_idle = ~wb_cyc;

  // --------------------------------------------------
  // Bus cycle control
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
    end else if (req_pop) begin
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
    end else if (wb_stb && wb_ack) begin
      // Drop cyc and stb the cycle after ack
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
    end
  end

  // Address held for the whole cycle
  always_ff @(posedge ap_clk) begin
    if (req_pop) wb_adr <= req_addr;
  end

  a_stb_in_cyc : assert property (@(posedge ap_clk) disable iff (control_areset)
    wb_stb |-> wb_cyc) else $error("wb_stb outside wb_cyc");

  a_adr_stable : assert property (@(posedge ap_clk) disable iff (control_areset)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
    else $error("Wishbone request changed before ack");

endmodule : cu_wb_master

// File: logic/cu_fifo.sv
// Synchronous FIFO, first-word fall-through
//   Type-parameterized payload, serves addresses and data words
//   Pointer pair plus occupancy count
module cu_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 8
) (
  input  logic     ap_clk,
  input  logic     control_areset,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     full,
  output logic     empty
);

  localparam int PTR_W = $clog2(DEPTH);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;

  // Head entry visible without a pop
  assign pop_data = mem[rd_ptr];
  assign full     = (count == (PTR_W + 1)'(DEPTH));
  assign empty    = (count == '0);

  // --------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Power-of-two depth, pointers wrap on their own
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge ap_clk) begin
    if (push) mem[wr_ptr] <= push_data;
  end

  a_push_not_full : assert property (@(posedge ap_clk) disable iff (control_areset)
    push |-> !full) else $error("FIFO push while full");

  a_pop_not_empty : assert property (@(posedge ap_clk) disable iff (control_areset)
    pop |-> !empty) else $error("FIFO pop while empty");

endmodule : cu_fifo

// File: logic/cu_setup_engine.sv
// Setup engine for configuration reads
//   Walks base .. base+count-1 into the request FIFO
//   Flags issue_done once every address is pushed
module cu_setup_engine (
  input  logic                ap_clk,
  input  logic                control_areset,
  input  logic                run_start,
  input  cu_mem_pkg::addr_t   cfg_base,
  input  cu_ctrl_pkg::count_t cfg_count,
  input  logic                req_full,
  output logic                req_push,
  output cu_mem_pkg::addr_t   req_addr,
  output logic                issue_done
);

  import cu_mem_pkg::*;
  import cu_ctrl_pkg::*;

  addr_t  next_addr;
  count_t remaining;
  logic   active;

  // One push per cycle while there is room
  assign req_push = active & ~req_full;
  assign req_addr = next_addr;

  // --------------------------------------------------
  // Issue control
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      active     <= 1'b0;
      issue_done <= 1'b0;
    end else if (run_start) begin
      // Zero count finishes straight away
      active     <= (cfg_count != '0);
      issue_done <= (cfg_count == '0);
    end else if (req_push && remaining == count_t'(1)) begin
      active     <= 1'b0;
      issue_done <= 1'b1;
    end
  end

  // Address walk and words left
  always_ff @(posedge ap_clk) begin
    if (run_start) begin
      next_addr <= cfg_base;
      remaining <= cfg_count;
    end else if (req_push) begin
      next_addr <= next_addr + addr_t'(1);
      remaining <= remaining - count_t'(1);
    end
  end

  // Every push stays inside the held descriptor window
  a_no_push_full : assert property (@(posedge ap_clk) disable iff (control_areset)
    req_push |-> !req_full && (req_addr - cfg_base) < addr_t'(cfg_count))
    else $error("request push while FIFO full or outside the descriptor window");

endmodule : cu_setup_engine

// File: logic/cu_control.sv
// Block-protocol FSM, ap_ctrl_chain style
//   Start handshake, run and drain tracking
//   Settle timer ahead of ap_done, ap_continue back to idle
module cu_control #(
  parameter int SETTLE_CYCLES = cu_ctrl_pkg::SETTLE_CYCLES_DEFAULT
) (
  input  logic ap_clk,
  input  logic control_areset,
  input  logic ap_start,
  input  logic ap_continue,
  input  logic desc_loaded,
  input  logic issue_done,
  input  logic mem_idle,
  input  logic req_empty,
  input  logic rsp_empty,
  output logic ap_ready,
  output logic ap_idle,
  output logic ap_done,
  output logic run_start,
  output logic desc_consume
);

  import cu_ctrl_pkg::*;

  localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

  cu_state_e        state;
  cu_state_e        state_nxt;
  logic [CNT_W-1:0] settle_cnt;
  logic             accept;
  logic             drained;

  // --------------------------------------------------
  // Handshake decode
  // --------------------------------------------------
  assign accept       = (state == CU_IDLE) & ap_start & desc_loaded;
  assign drained      = mem_idle & req_empty & rsp_empty;
  // Ready and run_start in the accept cycle, idle drops after
  assign ap_ready     = accept;
  assign run_start    = accept;
  assign ap_idle      = (state == CU_IDLE);
  assign ap_done      = (state == CU_DONE);
  assign desc_consume = (state == CU_DONE) & ap_continue;

  always_comb begin
    state_nxt = state;
    unique case (state)
      CU_IDLE:   if (accept) state_nxt = CU_RUN;
      CU_RUN:    if (issue_done) state_nxt = CU_DRAIN;
      CU_DRAIN:  if (drained) state_nxt = CU_SETTLE;
      CU_SETTLE: if (settle_cnt == '0) state_nxt = CU_DONE;
      CU_DONE:   if (ap_continue) state_nxt = CU_IDLE;
      default:   state_nxt = CU_IDLE;
    endcase
  end

  // --------------------------------------------------
  // State and settle timer
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      state      <= CU_IDLE;
      settle_cnt <= '0;
    end else begin
      state <= state_nxt;
      // Load on drain exit, count down while settling
      if (state == CU_DRAIN) begin
        settle_cnt <= CNT_W'(SETTLE_CYCLES - 1);
      end else if (state == CU_SETTLE) begin
        settle_cnt <= settle_cnt - 1'b1;
      end
    end
  end

  a_ready_pulse : assert property (@(posedge ap_clk) disable iff (control_areset)
    ap_ready |=> !ap_ready)
    else $error("ap_ready held longer than one cycle");

  // Done only after leaving idle, with bus and FIFOs still quiet
  a_done_not_idle : assert property (@(posedge ap_clk) disable iff (control_areset)
    $rose(ap_done) |-> !ap_idle && drained)
    else $error("ap_done rose while idle or with traffic pending");

endmodule : cu_control

// File: logic/cu_config_regs.sv
// Descriptor register block
//   Captures base address and word count for one run
//   Holds them until the control FSM consumes the descriptor
module cu_config_regs (
  input  logic                ap_clk,
  input  logic                control_areset,
  input  logic                desc_valid,
  input  cu_mem_pkg::addr_t   desc_base,
  input  cu_ctrl_pkg::count_t desc_count,
  input  logic                desc_consume,
  output logic                desc_loaded,
  output cu_mem_pkg::addr_t   cfg_base,
  output cu_ctrl_pkg::count_t cfg_count
);

  logic capture;

  // New descriptor only when the slot is free
  assign capture = desc_valid & ~desc_loaded;

  // --------------------------------------------------
  // Loaded flag
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      desc_loaded <= 1'b0;
    end else if (desc_consume) begin
      desc_loaded <= 1'b0;
    end else if (capture) begin
      desc_loaded <= 1'b1;
    end
  end

  // Payload, qualified by desc_loaded
  always_ff @(posedge ap_clk) begin
    if (capture) begin
      cfg_base  <= desc_base;
      cfg_count <= desc_count;
    end
  end

  // Control FSM only retires a descriptor it started from
  a_consume_loaded : assert property (@(posedge ap_clk) disable iff (control_areset)
    desc_consume |-> desc_loaded)
    else $error("desc_consume without a loaded descriptor");

endmodule : cu_config_regs

// File: logic/cu_mem_pkg.sv
// Memory-side definitions for the compute unit
//   addr_t             word address on the Wishbone side
//   data_t             configuration word
//   FIFO_DEPTH_DEFAULT entries in request and response FIFOs
package cu_mem_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;

  // Word address, one count per configuration word
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // One configuration word as read from memory
  typedef logic [DATA_WIDTH-1:0] data_t;

  // --------------------------------------------------
  // Buffering
  // --------------------------------------------------
  // Power of two, 2 or more
  localparam int FIFO_DEPTH_DEFAULT = 8;

endpackage : cu_mem_pkg

// File: logic/cu_ctrl_pkg.sv
// Control-side definitions for the compute unit
//   count_t               word count of one descriptor
//   cu_state_e            block-protocol FSM states
//   SETTLE_CYCLES_DEFAULT quiet time before ap_done
package cu_ctrl_pkg;

  // --------------------------------------------------
  // Descriptor word count
  // --------------------------------------------------
  localparam int COUNT_WIDTH = 16;

  typedef logic [COUNT_WIDTH-1:0] count_t;

  // --------------------------------------------------
  // Block-protocol states
  // --------------------------------------------------
  // Drain waits on bus and FIFOs, settle on the timer
  typedef enum logic [2:0] {
    CU_IDLE,
    CU_RUN,
    CU_DRAIN,
    CU_SETTLE,
    CU_DONE
  } cu_state_e;

  // Cycles between full drain and ap_done
  localparam int SETTLE_CYCLES_DEFAULT = 16;

endpackage : cu_ctrl_pkg
